// ==== src/rv32i_pkg.sv ====
package rv32i_pkg;

    // architectural data and address word
    typedef logic [31:0] rv32i_word;

    // architectural register index, x0 is hardwired to zero
    typedef logic [4:0] rv32i_reg;

    // number of architectural registers
    localparam int NUM_REGS = 32;

endpackage : rv32i_pkg

// ==== src/rob_pkg.sv ====
package rob_pkg;

    // reorder buffer entry number
    // 0 means no pending producer, live entries run 1 to ROB_DEPTH
    typedef logic [3:0] tag_t;

    // what an entry does when it reaches the head
    typedef enum logic [1:0] {
        // writes a register, dest carries the register index
        REG = 2'd0,
        // store, address and data come in on the memory bus
        ST  = 2'd1,
        // branch, dest carries the corrected target
        BR  = 2'd2
    } rob_op_e;

endpackage : rob_pkg

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer
    import rv32i_pkg::*;
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst,
    // dispatch from decode
    input  logic      disp_valid,
    input  rob_op_e   disp_op,
    input  rv32i_word disp_dest,
    output tag_t      alloc_tag,
    output logic      full,
    // alu result bus
    input  logic      alu_valid,
    input  tag_t      alu_tag,
    input  rv32i_word alu_val,
    // compare / branch result bus
    input  logic      cmp_valid,
    input  tag_t      cmp_tag,
    input  rv32i_word cmp_val,
    input  logic      cmp_mispredict,
    // load / store result bus
    input  logic      mem_valid,
    input  tag_t      mem_tag,
    input  rv32i_word mem_addr,
    input  rv32i_word mem_val,
    // operand lookups from the register status file
    input  tag_t      query_tag_a,
    input  tag_t      query_tag_b,
    output logic      query_ready_a,
    output logic      query_ready_b,
    output rv32i_word query_val_a,
    output rv32i_word query_val_b,
    // register commit
    output logic      commit_reg,
    output rv32i_reg  commit_rd,
    output rv32i_word commit_val,
    output tag_t      commit_tag,
    // store commit
    output logic      mem_write,
    output rv32i_word mem_address,
    output rv32i_word mem_wdata,
    // mispredict recovery
    output logic      flush,
    output rv32i_word redirect_pc
);

    // per-entry fields, slot 0 is never used
    logic      busy       [ROB_DEPTH + 1];
    logic      ready      [ROB_DEPTH + 1];
    rob_op_e   op         [ROB_DEPTH + 1];
    rv32i_word dest       [ROB_DEPTH + 1];
    rv32i_word value      [ROB_DEPTH + 1];
    logic      mispredict [ROB_DEPTH + 1];

    // next free slot, oldest live slot, live entry count
    tag_t in_head;
    tag_t commit_head;
    tag_t count;

    logic disp_ok;
    logic head_ready;

    // step a head pointer, wrapping ROB_DEPTH back to 1
    function automatic tag_t next_tag(input tag_t t);
        return (t == tag_t'(ROB_DEPTH)) ? tag_t'(1) : t + tag_t'(1);
    endfunction

    // stored state of an entry, overridden by any bus strobing that tag now
    function automatic void lookup(input tag_t t, output logic rdy, output rv32i_word val);
        rdy = (t != '0) && busy[t] && ready[t];
        val = value[t];
        if (alu_valid && alu_tag == t) begin
            rdy = 1'b1;
            val = alu_val;
        end
        if (cmp_valid && cmp_tag == t) begin
            rdy = 1'b1;
            val = cmp_val;
        end
        // only a load is ever looked up, so mem_val is the load data
        if (mem_valid && mem_tag == t) begin
            rdy = 1'b1;
            val = mem_val;
        end
    endfunction

    assign full      = (count == tag_t'(ROB_DEPTH));
    assign alloc_tag = in_head;
    assign disp_ok   = disp_valid && !full;

    always_comb begin
        lookup(query_tag_a, query_ready_a, query_val_a);
        lookup(query_tag_b, query_ready_b, query_val_b);
    end

    // head decode, commit is combinational in the cycle the head is ready
    assign head_ready  = busy[commit_head] && ready[commit_head];
    assign commit_reg  = head_ready && (op[commit_head] == REG);
    assign commit_rd   = rv32i_reg'(dest[commit_head]);
    assign commit_val  = value[commit_head];
    assign commit_tag  = commit_head;
    assign mem_write   = head_ready && (op[commit_head] == ST);
    assign mem_address = dest[commit_head];
    assign mem_wdata   = value[commit_head];
    assign flush       = head_ready && (op[commit_head] == BR) && mispredict[commit_head];
    assign redirect_pc = dest[commit_head];

    // control state: occupancy, ready flags and pointers
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // empty every entry, pointers back to 1
            for (int i = 0; i <= ROB_DEPTH; i++) begin
                busy[i]  <= 1'b0;
                ready[i] <= 1'b0;
            end
            in_head     <= tag_t'(1);
            commit_head <= tag_t'(1);
            count       <= '0;
        end else begin
            if (alu_valid) begin
                ready[alu_tag] <= 1'b1;
            end
            if (cmp_valid) begin
                ready[cmp_tag] <= 1'b1;
            end
            if (mem_valid) begin
                ready[mem_tag] <= 1'b1;
            end
            if (disp_ok) begin
                busy[in_head]  <= 1'b1;
                ready[in_head] <= 1'b0;
                in_head        <= next_tag(in_head);
            end
            if (head_ready) begin
                // retire the head
                busy[commit_head]  <= 1'b0;
                ready[commit_head] <= 1'b0;
                commit_head        <= next_tag(commit_head);
            end
            case ({disp_ok, head_ready})
                2'b10:   count <= count + tag_t'(1);
                2'b01:   count <= count - tag_t'(1);
                default: count <= count;
            endcase
        end
    end

    // entry payload, meaningful only while busy
    always_ff @(posedge clk) begin
        if (alu_valid) begin
            value[alu_tag] <= alu_val;
        end
        if (cmp_valid) begin
            // a branch only keeps the mispredict flag, slt keeps its result
            mispredict[cmp_tag] <= cmp_mispredict;
            if (op[cmp_tag] == REG) begin
                value[cmp_tag] <= cmp_val;
            end
        end
        if (mem_valid) begin
            value[mem_tag] <= mem_val;
            // store address replaces dest
            if (op[mem_tag] == ST) begin
                dest[mem_tag] <= mem_addr;
            end
        end
        if (disp_ok) begin
            op[in_head]   <= disp_op;
            dest[in_head] <= disp_dest;
        end
    end

    // decode must hold off while full
    a_no_disp_full: assert property (
        @(posedge clk) disable iff (rst) disp_valid |-> !full
    );

    // a result must land on a live entry still waiting for it
    property p_live_target(logic v, tag_t t);
        @(posedge clk) disable iff (rst || flush)
        v |-> (t != '0) && (t <= tag_t'(ROB_DEPTH)) && busy[t] && !ready[t];
    endproperty

    a_alu_target: assert property (p_live_target(alu_valid, alu_tag));
    a_cmp_target: assert property (p_live_target(cmp_valid, cmp_tag));
    a_mem_target: assert property (p_live_target(mem_valid, mem_tag));

    // buses firing together must carry different tags
    a_bus_tags_distinct: assert property (
        @(posedge clk) disable iff (rst)
        !(alu_valid && cmp_valid && alu_tag == cmp_tag) &&
        !(alu_valid && mem_valid && alu_tag == mem_tag) &&
        !(cmp_valid && mem_valid && cmp_tag == mem_tag)
    );

endmodule : reorder_buffer

// ==== src/reg_status_file.sv ====
`timescale 1ns/1ps

module reg_status_file
    import rv32i_pkg::*;
    import rob_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    // dispatch, records the new producer of rd
    input  logic      disp_valid,
    input  rob_op_e   disp_op,
    input  rv32i_reg  disp_rd,
    input  tag_t      alloc_tag,
    // register commit from the reorder buffer
    input  logic      commit_reg,
    input  rv32i_reg  commit_rd,
    input  rv32i_word commit_val,
    input  tag_t      commit_tag,
    // operand read ports
    input  rv32i_reg  rs1,
    input  rv32i_reg  rs2,
    output logic      rs1_ready,
    output logic      rs2_ready,
    output rv32i_word rs1_val,
    output rv32i_word rs2_val,
    output tag_t      rs1_tag,
    output tag_t      rs2_tag,
    // pending tag lookups answered by the reorder buffer
    output tag_t      query_tag_a,
    output tag_t      query_tag_b,
    input  logic      query_ready_a,
    input  logic      query_ready_b,
    input  rv32i_word query_val_a,
    input  rv32i_word query_val_b
);

    // committed values and newest pending producer per register
    rv32i_word regs     [NUM_REGS];
    tag_t      pend_tag [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i]     <= '0;
                pend_tag[i] <= '0;
            end
        end else begin
            if (commit_reg && commit_rd != '0) begin
                regs[commit_rd] <= commit_val;
                // a younger writer keeps its tag
                if (pend_tag[commit_rd] == commit_tag) begin
                    pend_tag[commit_rd] <= '0;
                end
            end
            if (flush) begin
                // every producer is gone, committed values stay
                for (int i = 0; i < NUM_REGS; i++) begin
                    pend_tag[i] <= '0;
                end
            end else if (disp_valid && disp_op == REG && disp_rd != '0) begin
                // newest producer wins over a same-cycle commit
                pend_tag[disp_rd] <= alloc_tag;
            end
        end
    end

    // rs1 port
    assign query_tag_a = pend_tag[rs1];
    assign rs1_tag     = query_tag_a;
    assign rs1_ready   = (query_tag_a == '0) || query_ready_a;
    assign rs1_val     = (query_tag_a == '0) ? regs[rs1] : query_val_a;

    // rs2 port
    assign query_tag_b = pend_tag[rs2];
    assign rs2_tag     = query_tag_b;
    assign rs2_ready   = (query_tag_b == '0) || query_ready_b;
    assign rs2_val     = (query_tag_b == '0) ? regs[rs2] : query_val_b;

    // a register commit always finds its own or a younger producer still pending
    a_commit_has_producer: assert property (
        @(posedge clk) disable iff (rst)
        (commit_reg && commit_rd != '0) |-> (pend_tag[commit_rd] != '0)
    );

endmodule : reg_status_file

// ==== src/rob_commit_top.sv ====
`timescale 1ns/1ps

module rob_commit_top
    import rv32i_pkg::*;
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst,
    // dispatch
    input  logic      disp_valid,
    input  rob_op_e   disp_op,
    input  rv32i_word disp_dest,
    input  rv32i_reg  disp_rd,
    output tag_t      alloc_tag,
    output logic      full,
    // alu result bus
    input  logic      alu_valid,
    input  tag_t      alu_tag,
    input  rv32i_word alu_val,
    // compare / branch result bus
    input  logic      cmp_valid,
    input  tag_t      cmp_tag,
    input  rv32i_word cmp_val,
    input  logic      cmp_mispredict,
    // load / store result bus
    input  logic      mem_valid,
    input  tag_t      mem_tag,
    input  rv32i_word mem_addr,
    input  rv32i_word mem_val,
    // operand read ports
    input  rv32i_reg  rs1,
    input  rv32i_reg  rs2,
    output logic      rs1_ready,
    output logic      rs2_ready,
    output rv32i_word rs1_val,
    output rv32i_word rs2_val,
    output tag_t      rs1_tag,
    output tag_t      rs2_tag,
    // register commit
    output logic      commit_reg,
    output rv32i_reg  commit_rd,
    output rv32i_word commit_val,
    output tag_t      commit_tag,
    // store port
    output logic      mem_write,
    output rv32i_word mem_address,
    output rv32i_word mem_wdata,
    // flush and redirect
    output logic      flush,
    output rv32i_word redirect_pc
);

    // operand lookup between status file and reorder buffer
    tag_t      query_tag_a;
    tag_t      query_tag_b;
    logic      query_ready_a;
    logic      query_ready_b;
    rv32i_word query_val_a;
    rv32i_word query_val_b;

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) reorder_buffer_inst (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_op        (disp_op),
        .disp_dest      (disp_dest),
        .alloc_tag      (alloc_tag),
        .full           (full),
        .alu_valid      (alu_valid),
        .alu_tag        (alu_tag),
        .alu_val        (alu_val),
        .cmp_valid      (cmp_valid),
        .cmp_tag        (cmp_tag),
        .cmp_val        (cmp_val),
        .cmp_mispredict (cmp_mispredict),
        .mem_valid      (mem_valid),
        .mem_tag        (mem_tag),
        .mem_addr       (mem_addr),
        .mem_val        (mem_val),
        .query_tag_a    (query_tag_a),
        .query_tag_b    (query_tag_b),
        .query_ready_a  (query_ready_a),
        .query_ready_b  (query_ready_b),
        .query_val_a    (query_val_a),
        .query_val_b    (query_val_b),
        .commit_reg     (commit_reg),
        .commit_rd      (commit_rd),
        .commit_val     (commit_val),
        .commit_tag     (commit_tag),
        .mem_write      (mem_write),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata),
        .flush          (flush),
        .redirect_pc    (redirect_pc)
    );

    reg_status_file reg_status_file_inst (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_rd       (disp_rd),
        .alloc_tag     (alloc_tag),
        .commit_reg    (commit_reg),
        .commit_rd     (commit_rd),
        .commit_val    (commit_val),
        .commit_tag    (commit_tag),
        .rs1           (rs1),
        .rs2           (rs2),
        .rs1_ready     (rs1_ready),
        .rs2_ready     (rs2_ready),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .rs1_tag       (rs1_tag),
        .rs2_tag       (rs2_tag),
        .query_tag_a   (query_tag_a),
        .query_tag_b   (query_tag_b),
        .query_ready_a (query_ready_a),
        .query_ready_b (query_ready_b),
        .query_val_a   (query_val_a),
        .query_val_b   (query_val_b)
    );

endmodule : rob_commit_top

// ==== include/rob_commit_vectors.svh ====
// columns: kind, op or bus, rd or program-order index, rs1, addr/dest/mispredict, value, expected
// expected is the alloc tag on a dispatch, the rs1 value after a drain and the full flag on fullchk
localparam int NUM_ROWS = 49;

task automatic load_table();
    // five producers with a store between them and a second writer to x1
    add_row(DISP,    REG,     1,  0,  32'h0,    32'h0,    32'd1);
    add_row(DISP,    REG,     2,  1,  32'h0,    32'h0,    32'd2);
    add_row(DISP,    ST,      0,  1,  32'h0,    32'h0,    32'd3);
    add_row(DISP,    REG,     3,  2,  32'h0,    32'h0,    32'd4);
    add_row(DISP,    REG,     1,  1,  32'h0,    32'h0,    32'd5);
    add_row(RESULT,  ALU_BUS, 0,  1,  32'h0,    32'h11,   32'h0);
    add_row(RESULT,  MEM_BUS, 1,  2,  32'h0,    32'h22,   32'h0);
    add_row(RESULT,  MEM_BUS, 2,  1,  32'h1000, 32'hdead, 32'h0);
    add_row(RESULT,  ALU_BUS, 3,  3,  32'h0,    32'h33,   32'h0);
    add_row(RESULT,  MEM_BUS, 4,  1,  32'h0,    32'h55,   32'h0);
    add_row(DRAIN,   0,       0,  1,  32'h0,    32'h0,    32'h55);
    add_row(DRAIN,   0,       0,  2,  32'h0,    32'h0,    32'h22);
    add_row(DRAIN,   0,       0,  3,  32'h0,    32'h0,    32'h33);
    // fill every entry, tags wrap past ROB_DEPTH
    add_row(DISP,    REG,     4,  1,  32'h0,    32'h0,    32'd6);
    add_row(DISP,    REG,     5,  1,  32'h0,    32'h0,    32'd7);
    add_row(DISP,    REG,     6,  1,  32'h0,    32'h0,    32'd8);
    add_row(DISP,    REG,     7,  1,  32'h0,    32'h0,    32'd1);
    add_row(DISP,    REG,     8,  1,  32'h0,    32'h0,    32'd2);
    add_row(DISP,    REG,     9,  1,  32'h0,    32'h0,    32'd3);
    add_row(DISP,    REG,     10, 1,  32'h0,    32'h0,    32'd4);
    add_row(DISP,    REG,     11, 1,  32'h0,    32'h0,    32'd5);
    add_row(FULLCHK, 0,       0,  4,  32'h0,    32'h0,    32'd1);
    add_row(RESULT,  ALU_BUS, 5,  4,  32'h0,    32'h44,   32'h0);
    add_row(FULLCHK, 0,       0,  4,  32'h0,    32'h0,    32'd1);
    add_row(FULLCHK, 0,       0,  4,  32'h0,    32'h0,    32'd0);
    add_row(RESULT,  CMP_BUS, 6,  5,  32'h0,    32'h1,    32'h0);
    add_row(RESULT,  ALU_BUS, 7,  6,  32'h0,    32'h7,    32'h0);
    add_row(RESULT,  MEM_BUS, 8,  7,  32'h0,    32'h8,    32'h0);
    add_row(RESULT,  ALU_BUS, 9,  8,  32'h0,    32'h9,    32'h0);
    add_row(RESULT,  MEM_BUS, 10, 9,  32'h0,    32'ha,    32'h0);
    add_row(RESULT,  ALU_BUS, 11, 10, 32'h0,    32'hb,    32'h0);
    add_row(RESULT,  CMP_BUS, 12, 11, 32'h0,    32'h0,    32'h0);
    add_row(DRAIN,   0,       0,  5,  32'h0,    32'h0,    32'h1);
    // good branch, producer, mispredicted branch, then younger work that must vanish
    add_row(DISP,    BR,      0,  0,  32'h200,  32'h0,    32'd6);
    add_row(DISP,    REG,     6,  6,  32'h0,    32'h0,    32'd7);
    add_row(DISP,    BR,      0,  6,  32'h400,  32'h0,    32'd8);
    add_row(DISP,    REG,     12, 6,  32'h0,    32'h0,    32'd1);
    add_row(DISP,    ST,      0,  12, 32'h0,    32'h0,    32'd2);
    add_row(RESULT,  ALU_BUS, 16, 12, 32'h0,    32'h99,   32'h0);
    add_row(RESULT,  MEM_BUS, 17, 12, 32'h2000, 32'hbeef, 32'h0);
    add_row(FULLCHK, 0,       0,  12, 32'h0,    32'h0,    32'd0);
    add_row(RESULT,  CMP_BUS, 13, 6,  32'h0,    32'h0,    32'h0);
    add_row(RESULT,  ALU_BUS, 14, 6,  32'h0,    32'h66,   32'h0);
    add_row(RESULT,  CMP_BUS, 15, 6,  32'h1,    32'h0,    32'h0);
    add_row(DRAIN,   0,       0,  6,  32'h0,    32'h0,    32'h66);
    add_row(DRAIN,   0,       0,  12, 32'h0,    32'h0,    32'h0);
    // allocation restarts at 1 after the flush
    add_row(DISP,    REG,     13, 13, 32'h0,    32'h0,    32'd1);
    add_row(RESULT,  ALU_BUS, 18, 13, 32'h0,    32'h13,   32'h0);
    add_row(DRAIN,   0,       0,  13, 32'h0,    32'h0,    32'h13);
endtask

// ==== sim/rob_commit_tb.sv ====
`timescale 1ns/1ps

module rob_commit_tb
    import rv32i_pkg::*;
    import rob_pkg::*;
;

    localparam int ROB_DEPTH  = 8;
    localparam int CLK_PERIOD = 20;
    localparam int SEED       = 32'h27f4;
    // row kinds and result bus selects
    localparam int DISP    = 1;
    localparam int RESULT  = 2;
    localparam int DRAIN   = 3;
    localparam int FULLCHK = 4;
    localparam int ALU_BUS = 0;
    localparam int CMP_BUS = 1;
    localparam int MEM_BUS = 2;

    `include "rob_commit_vectors.svh"

    logic clk = 1'b0;
    logic rst;
    logic disp_valid, alu_valid, cmp_valid, cmp_mispredict, mem_valid;
    rob_op_e disp_op;
    rv32i_word disp_dest, alu_val, cmp_val, mem_addr, mem_val;
    rv32i_reg disp_rd, rs1, rs2;
    tag_t alu_tag, cmp_tag, mem_tag;
    tag_t alloc_tag, rs1_tag, rs2_tag, commit_tag;
    logic full, rs1_ready, rs2_ready, commit_reg, mem_write, flush;
    rv32i_word rs1_val, rs2_val, commit_val, mem_address, mem_wdata, redirect_pc;
    rv32i_reg commit_rd;

    // stimulus table columns
    int        t_kind [NUM_ROWS];
    int        t_sel  [NUM_ROWS];
    int        t_rd   [NUM_ROWS];
    int        t_rs1  [NUM_ROWS];
    rv32i_word t_a    [NUM_ROWS];
    rv32i_word t_v    [NUM_ROWS];
    rv32i_word t_exp  [NUM_ROWS];
    int        rows = 0;

    // reference model, entries indexed by program order
    int        ent_op    [64];
    int        ent_rd    [64];
    rv32i_word ent_dest  [64];
    rv32i_word ent_val   [64];
    logic      ent_ready [64];
    logic      ent_misp  [64];
    tag_t      ent_tag   [64];
    int        tag_seq   [16];
    int        pq[$];
    rv32i_word regs [NUM_REGS];
    tag_t      pend [NUM_REGS];
    tag_t      in_tag;
    int        next_seq;
    int        errors = 0;

    rob_commit_top #(.ROB_DEPTH(ROB_DEPTH)) rob_commit_top_inst (
        .clk(clk), .rst(rst),
        .disp_valid(disp_valid), .disp_op(disp_op), .disp_dest(disp_dest), .disp_rd(disp_rd),
        .alloc_tag(alloc_tag), .full(full),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_val(alu_val),
        .cmp_valid(cmp_valid), .cmp_tag(cmp_tag), .cmp_val(cmp_val),
        .cmp_mispredict(cmp_mispredict),
        .mem_valid(mem_valid), .mem_tag(mem_tag), .mem_addr(mem_addr), .mem_val(mem_val),
        .rs1(rs1), .rs2(rs2), .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .commit_reg(commit_reg), .commit_rd(commit_rd), .commit_val(commit_val),
        .commit_tag(commit_tag),
        .mem_write(mem_write), .mem_address(mem_address), .mem_wdata(mem_wdata),
        .flush(flush), .redirect_pc(redirect_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_row(input int kind, input int sel, input int rd, input int rs1_sel,
                           input rv32i_word a, input rv32i_word v, input rv32i_word exp);
        t_kind[rows] = kind;
        t_sel[rows]  = sel;
        t_rd[rows]   = rd;
        t_rs1[rows]  = rs1_sel;
        t_a[rows]    = a;
        t_v[rows]    = v;
        t_exp[rows]  = exp;
        rows++;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // a read port follows the pending tag, a bus strobing that tag answers at once
    task automatic check_read_port(input string port, input rv32i_reg r, input logic rdy,
                                   input rv32i_word val, input tag_t tg);
        logic bus_hit;
        tag_t t;
        t = pend[r];
        bus_hit = (alu_valid || cmp_valid || mem_valid) && (alu_tag == t);
        check({port, "_tag"}, tg, t);
        check({port, "_ready"}, rdy, (t == '0) || ent_ready[tag_seq[t]] || bus_hit);
        if (t == '0) begin
            check({port, "_val"}, val, regs[r]);
        end else if (bus_hit) begin
            check({port, "_val"}, val, alu_val);
        end else if (ent_ready[tag_seq[t]]) begin
            check({port, "_val"}, val, ent_val[tag_seq[t]]);
        end
    endtask

    // compare the cycle's outputs with the model, before the coming edge
    task automatic check_outputs();
        logic hr;
        int   s;
        hr = (pq.size() > 0) && ent_ready[pq[0]];
        s  = (pq.size() > 0) ? pq[0] : 0;
        check("full", full, pq.size() == ROB_DEPTH);
        check("alloc_tag", alloc_tag, in_tag);
        check("commit_reg", commit_reg, hr && ent_op[s] == REG);
        check("mem_write", mem_write, hr && ent_op[s] == ST);
        check("flush", flush, hr && ent_op[s] == BR && ent_misp[s]);
        if (hr && ent_op[s] == REG) begin
            check("commit_rd", commit_rd, ent_rd[s]);
            check("commit_val", commit_val, ent_val[s]);
            check("commit_tag", commit_tag, ent_tag[s]);
        end
        if (hr && ent_op[s] == ST) begin
            check("mem_address", mem_address, ent_dest[s]);
            check("mem_wdata", mem_wdata, ent_val[s]);
        end
        if (hr && ent_op[s] == BR && ent_misp[s]) begin
            check("redirect_pc", redirect_pc, ent_dest[s]);
        end
        check_read_port("rs1", rs1, rs1_ready, rs1_val, rs1_tag);
        check_read_port("rs2", rs2, rs2_ready, rs2_val, rs2_tag);
    endtask

    // what the coming edge does: retire the oldest ready entry, then results and dispatch
    task automatic advance_model();
        int   s;
        logic flushed;
        flushed = 1'b0;
        if (pq.size() > 0 && ent_ready[pq[0]]) begin
            s = pq.pop_front();
            if (ent_op[s] == REG && ent_rd[s] != 0) begin
                regs[ent_rd[s]] = ent_val[s];
                if (pend[ent_rd[s]] == ent_tag[s]) begin
                    pend[ent_rd[s]] = '0;
                end
            end
            if (ent_op[s] == BR && ent_misp[s]) begin
                flushed = 1'b1;
                pq.delete();
                in_tag = tag_t'(1);
                for (int r = 0; r < NUM_REGS; r++) begin
                    pend[r] = '0;
                end
            end
        end
        if (!flushed) begin
            if (alu_valid || cmp_valid || mem_valid) begin
                s = tag_seq[alu_tag];
                ent_ready[s] = 1'b1;
                ent_val[s]   = alu_val;
                if (cmp_valid) begin
                    ent_misp[s] = cmp_mispredict;
                end
                if (mem_valid && ent_op[s] == ST) begin
                    ent_dest[s] = mem_addr;
                end
            end
            if (disp_valid) begin
                ent_op[next_seq]    = int'(disp_op);
                ent_rd[next_seq]    = int'(disp_rd);
                ent_dest[next_seq]  = disp_dest;
                ent_ready[next_seq] = 1'b0;
                ent_misp[next_seq]  = 1'b0;
                ent_tag[next_seq]   = in_tag;
                tag_seq[in_tag]     = next_seq;
                pq.push_back(next_seq);
                if (disp_op == REG && disp_rd != '0) begin
                    pend[disp_rd] = in_tag;
                end
                in_tag = (in_tag == tag_t'(ROB_DEPTH)) ? tag_t'(1) : in_tag + tag_t'(1);
                next_seq++;
            end
        end
    endtask

    // one clock cycle: drive at the rising edge, check and advance the model at the falling edge
    task automatic step(input logic dv, input int op_sel, input int rd, input rv32i_word a,
                        input int bus, input tag_t tag, input rv32i_word v, input int rs1_sel);
        @(posedge clk);
        disp_valid     <= dv;
        disp_op        <= rob_op_e'(op_sel);
        // a register entry carries its rd in dest
        disp_dest      <= (op_sel == REG) ? rv32i_word'(rd) : a;
        disp_rd        <= rv32i_reg'(rd);
        alu_valid      <= (bus == ALU_BUS);
        cmp_valid      <= (bus == CMP_BUS);
        mem_valid      <= (bus == MEM_BUS);
        alu_tag        <= tag;
        cmp_tag        <= tag;
        mem_tag        <= tag;
        alu_val        <= v;
        cmp_val        <= v;
        mem_val        <= v;
        mem_addr       <= a;
        cmp_mispredict <= a[0];
        rs1            <= rv32i_reg'(rs1_sel);
        // rs2 watches the next register up
        rs2            <= rv32i_reg'(rs1_sel + 1);
        @(negedge clk);
        check_outputs();
        advance_model();
    endtask

    initial begin
        #(NUM_ROWS * 40 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", NUM_ROWS * 40);
        $display("Test failed");
        $finish;
    end

    initial begin
        int i;
        int k;
        int j;
        int r;
        int grp[$];
        void'($urandom(SEED));
        rst = 1'b1;
        {disp_valid, alu_valid, cmp_valid, mem_valid, cmp_mispredict} = '0;
        disp_op = REG;
        {disp_dest, alu_val, cmp_val, mem_addr, mem_val} = '0;
        {disp_rd, rs1, rs2} = '0;
        {alu_tag, cmp_tag, mem_tag} = '0;
        for (k = 0; k < NUM_REGS; k++) begin
            regs[k] = '0;
            pend[k] = '0;
        end
        in_tag   = tag_t'(1);
        next_seq = 0;
        load_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        i = 0;
        while (i < NUM_ROWS) begin
            case (t_kind[i])
                DISP: begin
                    step(1'b1, t_sel[i], t_rd[i], t_a[i], -1, '0, '0, t_rs1[i]);
                    check("alloc_tag", alloc_tag, t_exp[i]);
                    i++;
                end
                RESULT: begin
                    // consecutive result rows form a group applied in shuffled order
                    grp.delete();
                    while (i < NUM_ROWS && t_kind[i] == RESULT) begin
                        grp.push_back(i);
                        i++;
                    end
                    for (k = grp.size() - 1; k > 0; k--) begin
                        j      = int'($urandom % (k + 1));
                        r      = grp[k];
                        grp[k] = grp[j];
                        grp[j] = r;
                    end
                    for (k = 0; k < grp.size(); k++) begin
                        r = grp[k];
                        step(1'b0, 0, 0, t_a[r], t_sel[r], ent_tag[t_rd[r]], t_v[r], t_rs1[r]);
                    end
                end
                DRAIN: begin
                    // idle until the model has retired everything
                    while (pq.size() > 0) begin
                        step(1'b0, 0, 0, '0, -1, '0, '0, t_rs1[i]);
                    end
                    step(1'b0, 0, 0, '0, -1, '0, '0, t_rs1[i]);
                    check("rs1_ready", rs1_ready, 1'b1);
                    check("rs1_val", rs1_val, t_exp[i]);
                    i++;
                end
                default: begin
                    step(1'b0, 0, 0, '0, -1, '0, '0, t_rs1[i]);
                    check("full", full, t_exp[i]);
                    i++;
                end
            endcase
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : rob_commit_tb

// ==== rob_commit.f ====
+incdir+include
src/rv32i_pkg.sv
src/rob_pkg.sv
src/reorder_buffer.sv
src/reg_status_file.sv
src/rob_commit_top.sv
sim/rob_commit_tb.sv
